// File: bench/ctrl_ref_model.svh
`ifndef CTRL_REF_MODEL_SVH
`define CTRL_REF_MODEL_SVH

// cycle model of the controller, evaluated once per cycle before the edge
// reads the testbench input variables directly

ctrl_state_e m_state;
ctrl_state_e m_next;

// expected status and stall outputs
logic exp_busy;
logic exp_first_fetch;
logic exp_decoding;
logic exp_deassert_we;
logic exp_req;
logic exp_halt_if;
logic exp_halt_id;
logic exp_kill;

// expected redirect, causes and strobes
logic                      exp_pc_set;
logic [`CTRL_PC_MUX_W-1:0] exp_pc_mux;
logic [`CTRL_EXC_PC_W-1:0] exp_exc_pc_mux;
logic [`CTRL_CAUSE_W-1:0]  exp_exc_cause;
logic [`CTRL_CAUSE_W-1:0]  exp_csr_cause;
logic                      exp_save_if;
logic                      exp_save_id;
logic                      exp_save_cause;
logic                      exp_restore;
logic                      exp_irq_ack;
logic                      exp_exc_ack;
logic                      exp_perf_jump;
logic                      exp_perf_tbranch;

// stop fetch and decode, leave for the given state
task automatic halt_into(input ctrl_state_e target);
  m_next      = target;
  exp_halt_if = 1'b1;
  exp_halt_id = 1'b1;
endtask

// synchronous trap, id stage pc goes to mepc
task automatic expect_sync_trap(input logic [`CTRL_EXC_PC_W-1:0] vec,
                                input logic [`CTRL_CAUSE_W-1:0] cause);
  exp_pc_set     = 1'b1;
  exp_pc_mux     = PC_EXCEPTION;
  exp_exc_pc_mux = vec;
  exp_exc_cause  = cause;
  exp_csr_cause  = cause;
  exp_save_id    = 1'b1;
  exp_save_cause = 1'b1;
endtask

task automatic model_eval();
  logic irq_on;
  logic safe;
  logic any_flush;

  irq_on    = irq_req & m_ie;
  safe      = !instr_multicycle && !branch_in_id;
  any_flush = illegal_insn | ecall_insn | mret_insn | pipe_flush |
              ebrk_insn | csr_status;

  // running fetch, nothing redirected
  m_next           = m_state;
  exp_busy         = 1'b1;
  exp_req          = 1'b1;
  exp_first_fetch  = 1'b0;
  exp_decoding     = 1'b0;
  exp_halt_if      = 1'b0;
  exp_halt_id      = 1'b0;
  exp_kill         = 1'b0;
  exp_pc_set       = 1'b0;
  exp_pc_mux       = PC_BOOT;
  exp_exc_pc_mux   = EXC_PC_IRQ;
  exp_exc_cause    = '0;
  exp_csr_cause    = '0;
  exp_save_if      = 1'b0;
  exp_save_id      = 1'b0;
  exp_save_cause   = 1'b0;
  exp_restore      = 1'b0;
  exp_irq_ack      = 1'b0;
  exp_exc_ack      = 1'b0;
  exp_perf_jump    = 1'b0;
  exp_perf_tbranch = 1'b0;

  case (m_state)
    RESET: begin
      exp_busy = 1'b0;
      exp_req  = 1'b0;
      if (fetch_enable) m_next = BOOT_SET;
    end
    BOOT_SET: begin
      exp_pc_set = 1'b1;
      m_next     = FIRST_FETCH;
    end
    WAIT_SLEEP: begin
      exp_busy = 1'b0;
      exp_req  = 1'b0;
      halt_into(SLEEP);
    end
    SLEEP: begin
      exp_busy = 1'b0;
      exp_req  = 1'b0;
      // masked requests wake it too
      halt_into((fetch_enable || irq_req) ? FIRST_FETCH : SLEEP);
    end
    FIRST_FETCH: begin
      exp_first_fetch = 1'b1;
      if (irq_on) halt_into(IRQ_TAKEN);
      else if (id_ready) m_next = DECODE;
    end
    DECODE: begin
      if (instr_valid) begin
        exp_decoding = 1'b1;
        if (branch_set || jump_set) begin
          exp_pc_set       = 1'b1;
          exp_pc_mux       = PC_JUMP;
          exp_perf_tbranch = branch_set;
          exp_perf_jump    = !branch_set;
        end else if (any_flush) begin
          halt_into(FLUSH);
        end else if (irq_on && safe) begin
          halt_into(IRQ_TAKEN);
        end else begin
          exp_kill = irq_req && !m_ie && safe;
        end
      end else if (irq_on) begin
        halt_into(IRQ_TAKEN);
      end
    end
    IRQ_TAKEN: begin
      exp_pc_set     = 1'b1;
      exp_pc_mux     = PC_EXCEPTION;
      exp_exc_cause  = {1'b0, irq_id};
      exp_csr_cause  = {1'b1, irq_id};
      exp_save_if    = 1'b1;
      exp_save_cause = 1'b1;
      exp_irq_ack    = 1'b1;
      exp_exc_ack    = 1'b1;
      m_next         = DECODE;
    end
    FLUSH: begin
      exp_halt_if = !fetch_enable;
      exp_halt_id = 1'b1;
      if (ecall_insn) expect_sync_trap(EXC_PC_ECALL, `CTRL_CAUSE_ECALL_M);
      if (illegal_insn) expect_sync_trap(EXC_PC_ILLINSN, `CTRL_CAUSE_ILLEGAL);
      if (mret_insn) begin
        exp_pc_set  = 1'b1;
        exp_pc_mux  = PC_ERET;
        exp_restore = 1'b1;
      end
      if (ebrk_insn) exp_exc_cause = `CTRL_CAUSE_BREAKPOINT;
      // wfi-like exit when fetch is off
      if (!fetch_enable && (mret_insn || pipe_flush)) m_next = WAIT_SLEEP;
      else m_next = DECODE;
    end
    default: begin
      exp_req = 1'b0;
      m_next  = RESET;
    end
  endcase

  exp_deassert_we = !exp_decoding || illegal_insn;
endtask

`endif

// File: bench/tb_core_ctrl.sv
`timescale 1ns/1ns

`include "core_ctrl_cfg.svh"

module tb_core_ctrl;

  import core_ctrl_pkg::*;

  localparam int RESET_CYCLES    = 5;
  localparam int DIRECTED_CYCLES = 40;
  localparam int RANDOM_CYCLES   = 2000;
  localparam int TOTAL_CYCLES    = RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES;

  // decoder flag indices, anything from 8 up means no flag
  localparam logic [3:0] FLAG_ILLEGAL = 4'd0;
  localparam logic [3:0] FLAG_ECALL   = 4'd1;
  localparam logic [3:0] FLAG_MRET    = 4'd2;
  localparam logic [3:0] FLAG_EBRK    = 4'd4;
  localparam logic [3:0] FLAG_BRANCH  = 4'd6;
  localparam logic [3:0] FLAG_JUMP    = 4'd7;
  localparam logic [3:0] FLAG_NONE    = 4'd8;

  logic clk;
  logic rst_n;
  logic fetch_enable;
  logic illegal_insn;
  logic ecall_insn;
  logic mret_insn;
  logic pipe_flush;
  logic ebrk_insn;
  logic csr_status;
  logic instr_valid;
  logic branch_in_id;
  logic branch_set;
  logic jump_set;
  logic instr_multicycle;
  logic irq_req;
  logic [`CTRL_IRQ_ID_W-1:0] irq_id;
  logic m_ie;
  logic id_ready;

  logic ctrl_busy_o, first_fetch_o, is_decoding_o, deassert_we_o;
  logic instr_req_o, halt_if_o, halt_id_o, exc_kill_o;
  logic [`CTRL_IRQ_ID_W-1:0] irq_id_o;
  logic pc_set_o;
  logic [`CTRL_PC_MUX_W-1:0] pc_mux_o;
  logic [`CTRL_EXC_PC_W-1:0] exc_pc_mux_o;
  logic [`CTRL_CAUSE_W-1:0] exc_cause_o, csr_cause_o;
  logic csr_save_if_o, csr_save_id_o, csr_save_cause_o, csr_restore_mret_o;
  logic irq_ack_o, exc_ack_o, perf_jump_o, perf_tbranch_o;

  integer seed;
  int     check_count;
  int     error_count;
  int     errors_before;
  // halt_id seen last cycle, decoder flags must not move after it
  logic   prev_halt_id;

  `include "ctrl_ref_model.svh"

  core_ctrl core_ctrl_i (
    .clk (clk), .rst_n (rst_n),
    .fetch_enable_i (fetch_enable), .illegal_insn_i (illegal_insn),
    .ecall_insn_i (ecall_insn), .mret_insn_i (mret_insn),
    .pipe_flush_i (pipe_flush), .ebrk_insn_i (ebrk_insn),
    .csr_status_i (csr_status), .instr_valid_i (instr_valid),
    .branch_in_id_i (branch_in_id), .branch_set_i (branch_set),
    .jump_set_i (jump_set), .instr_multicycle_i (instr_multicycle),
    .irq_req_i (irq_req), .irq_id_i (irq_id), .m_ie_i (m_ie),
    .id_ready_i (id_ready),
    .ctrl_busy_o (ctrl_busy_o), .first_fetch_o (first_fetch_o),
    .is_decoding_o (is_decoding_o), .deassert_we_o (deassert_we_o),
    .instr_req_o (instr_req_o), .halt_if_o (halt_if_o),
    .halt_id_o (halt_id_o), .exc_kill_o (exc_kill_o), .irq_id_o (irq_id_o),
    .pc_set_o (pc_set_o), .pc_mux_o (pc_mux_o), .exc_pc_mux_o (exc_pc_mux_o),
    .exc_cause_o (exc_cause_o), .csr_cause_o (csr_cause_o),
    .csr_save_if_o (csr_save_if_o), .csr_save_id_o (csr_save_id_o),
    .csr_save_cause_o (csr_save_cause_o), .csr_restore_mret_o (csr_restore_mret_o),
    .irq_ack_o (irq_ack_o), .exc_ack_o (exc_ack_o),
    .perf_jump_o (perf_jump_o), .perf_tbranch_o (perf_tbranch_o)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // checking
  //////////////////////////////////////////////////////////////////////

  task automatic check_val(input string name, input logic [31:0] exp_v,
                           input logic [31:0] act_v);
    check_count++;
    if (act_v !== exp_v) begin
      error_count++;
      $display("Error at %0t ns: %s expected %0h, got %0h", $time, name, exp_v, act_v);
    end
  endtask

  task automatic compare_all();
    check_val("ctrl_busy_o", 32'(exp_busy), 32'(ctrl_busy_o));
    check_val("first_fetch_o", 32'(exp_first_fetch), 32'(first_fetch_o));
    check_val("is_decoding_o", 32'(exp_decoding), 32'(is_decoding_o));
    check_val("deassert_we_o", 32'(exp_deassert_we), 32'(deassert_we_o));
    check_val("instr_req_o", 32'(exp_req), 32'(instr_req_o));
    check_val("halt_if_o", 32'(exp_halt_if), 32'(halt_if_o));
    check_val("halt_id_o", 32'(exp_halt_id), 32'(halt_id_o));
    check_val("exc_kill_o", 32'(exp_kill), 32'(exc_kill_o));
    check_val("irq_id_o", 32'(irq_id), 32'(irq_id_o));
    check_val("pc_set_o", 32'(exp_pc_set), 32'(pc_set_o));
    check_val("pc_mux_o", 32'(exp_pc_mux), 32'(pc_mux_o));
    check_val("exc_pc_mux_o", 32'(exp_exc_pc_mux), 32'(exc_pc_mux_o));
    check_val("exc_cause_o", 32'(exp_exc_cause), 32'(exc_cause_o));
    check_val("csr_cause_o", 32'(exp_csr_cause), 32'(csr_cause_o));
    check_val("csr_save_if_o", 32'(exp_save_if), 32'(csr_save_if_o));
    check_val("csr_save_id_o", 32'(exp_save_id), 32'(csr_save_id_o));
    check_val("csr_save_cause_o", 32'(exp_save_cause), 32'(csr_save_cause_o));
    check_val("csr_restore_mret_o", 32'(exp_restore), 32'(csr_restore_mret_o));
    check_val("irq_ack_o", 32'(exp_irq_ack), 32'(irq_ack_o));
    check_val("exc_ack_o", 32'(exp_exc_ack), 32'(exc_ack_o));
    check_val("perf_jump_o", 32'(exp_perf_jump), 32'(perf_jump_o));
    check_val("perf_tbranch_o", 32'(exp_perf_tbranch), 32'(perf_tbranch_o));
  endtask

  // outputs settle well before the falling edge
  task automatic sample();
    @(negedge clk);
    model_eval();
    compare_all();
    prev_halt_id = halt_id_o;
  endtask

  // model takes its edge, new inputs go out shortly after
  task automatic tick();
    @(posedge clk);
    m_state = m_next;
    #2;
  endtask

  task automatic step();
    sample();
    tick();
  endtask

  task automatic report_test(input string name);
    $display("test %s done, %0d errors", name, error_count - errors_before);
    errors_before = error_count;
  endtask

  // one decoder flag at a time
  task automatic set_flag(input logic [3:0] idx);
    illegal_insn = (idx == FLAG_ILLEGAL);
    ecall_insn   = (idx == FLAG_ECALL);
    mret_insn    = (idx == FLAG_MRET);
    pipe_flush   = (idx == 4'd3);
    ebrk_insn    = (idx == FLAG_EBRK);
    csr_status   = (idx == 4'd5);
    branch_set   = (idx == FLAG_BRANCH);
    jump_set     = (idx == FLAG_JUMP);
  endtask

  //////////////////////////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_reset_boot();
    sample();
    check_val("instr_req_o", 32'd0, 32'(instr_req_o));
    check_val("ctrl_busy_o", 32'd0, 32'(ctrl_busy_o));
    tick();
    fetch_enable = 1'b1;
    step();
    sample();
    check_val("pc_set_o", 32'd1, 32'(pc_set_o));
    check_val("pc_mux_o", 32'(PC_BOOT), 32'(pc_mux_o));
    tick();
    // back-pressure from id holds first fetch
    repeat (3) begin
      sample();
      check_val("first_fetch_o", 32'd1, 32'(first_fetch_o));
      tick();
    end
    id_ready = 1'b1;
    step();
    report_test("reset_boot");
  endtask

  task automatic test_branch_jump();
    instr_valid = 1'b1;
    set_flag(FLAG_BRANCH);
    sample();
    check_val("pc_mux_o", 32'(PC_JUMP), 32'(pc_mux_o));
    check_val("perf_tbranch_o", 32'd1, 32'(perf_tbranch_o));
    tick();
    set_flag(FLAG_JUMP);
    sample();
    check_val("pc_mux_o", 32'(PC_JUMP), 32'(pc_mux_o));
    check_val("perf_jump_o", 32'd1, 32'(perf_jump_o));
    tick();
    set_flag(FLAG_NONE);
    report_test("branch_jump");
  endtask

  // decode cycle, flush cycle, then a bubble while the flag is still held
  task automatic flush_trap(input logic [3:0] idx, input logic [31:0] cause);
    set_flag(idx);
    instr_valid = 1'b1;
    sample();
    if (idx == FLAG_ILLEGAL) check_val("deassert_we_o", 32'd1, 32'(deassert_we_o));
    tick();
    sample();
    check_val("exc_cause_o", cause, 32'(exc_cause_o));
    tick();
    instr_valid = 1'b0;
    step();
    set_flag(FLAG_NONE);
  endtask

  task automatic test_exceptions();
    flush_trap(FLAG_ECALL, 32'd11);
    flush_trap(FLAG_ILLEGAL, 32'd2);
    flush_trap(FLAG_EBRK, 32'd3);
    report_test("exceptions");
  endtask

  task automatic test_mret_sleep();
    fetch_enable = 1'b0;
    instr_valid  = 1'b1;
    set_flag(FLAG_MRET);
    step();
    sample();
    check_val("pc_mux_o", 32'(PC_ERET), 32'(pc_mux_o));
    check_val("csr_restore_mret_o", 32'd1, 32'(csr_restore_mret_o));
    tick();
    repeat (2) begin
      sample();
      check_val("instr_req_o", 32'd0, 32'(instr_req_o));
      check_val("ctrl_busy_o", 32'd0, 32'(ctrl_busy_o));
      tick();
    end
    // masked request still wakes the core
    irq_req = 1'b1;
    m_ie    = 1'b0;
    step();
    irq_req  = 1'b0;
    id_ready = 1'b0;
    sample();
    check_val("first_fetch_o", 32'd1, 32'(first_fetch_o));
    tick();
    set_flag(FLAG_NONE);
    fetch_enable = 1'b1;
    id_ready     = 1'b1;
    instr_valid  = 1'b0;
    step();
    report_test("mret_sleep");
  endtask

  task automatic test_interrupts();
    irq_req     = 1'b1;
    m_ie        = 1'b1;
    irq_id      = 5'd13;
    instr_valid = 1'b1;
    step();
    irq_req = 1'b0;
    sample();
    check_val("irq_ack_o", 32'd1, 32'(irq_ack_o));
    check_val("exc_ack_o", 32'd1, 32'(exc_ack_o));
    check_val("pc_set_o", 32'd1, 32'(pc_set_o));
    check_val("exc_cause_o", 32'd13, 32'(exc_cause_o));
    check_val("csr_cause_o", 32'd45, 32'(csr_cause_o));
    tick();
    // pending but masked in a safe window
    irq_req = 1'b1;
    m_ie    = 1'b0;
    sample();
    check_val("exc_kill_o", 32'd1, 32'(exc_kill_o));
    tick();
    irq_req = 1'b0;
    report_test("interrupts");
  endtask

  task automatic test_random(input int cycles);
    logic [31:0] rnd;
    for (int i = 0; i < cycles; i++) begin
      rnd              = $random(seed);
      fetch_enable     = (rnd[1:0] != 2'b00);
      instr_valid      = (rnd[3:2] != 2'b00);
      irq_req          = (rnd[6:4] == 3'b000);
      m_ie             = rnd[7];
      irq_id           = rnd[12:8];
      instr_multicycle = (rnd[14:13] == 2'b00);
      branch_in_id     = (rnd[16:15] == 2'b00);
      id_ready         = rnd[17];
      if (!prev_halt_id) set_flag(rnd[21:18]);
      step();
    end
    report_test("random");
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence and watchdog
  //////////////////////////////////////////////////////////////////////

  initial begin
    seed             = 32'h17c4;
    check_count      = 0;
    error_count      = 0;
    errors_before    = 0;
    prev_halt_id     = 1'b0;
    rst_n            = 1'b0;
    fetch_enable     = 1'b0;
    instr_valid      = 1'b0;
    branch_in_id     = 1'b0;
    instr_multicycle = 1'b0;
    irq_req          = 1'b0;
    irq_id           = '0;
    m_ie             = 1'b0;
    id_ready         = 1'b0;
    set_flag(FLAG_NONE);
    m_state = RESET;
    m_next  = RESET;
    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    rst_n = 1'b1;

    test_reset_boot();
    test_branch_jump();
    test_exceptions();
    test_mret_sleep();
    test_interrupts();
    test_random(RANDOM_CYCLES);

    $display("checks %0d, errors %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  initial begin
    #(TOTAL_CYCLES * 20 * 2);
    $display("simulation timed out before the tests finished");
    $display("=== FAIL ===");
    $finish;
  end

endmodule

// File: core_ctrl.f
+incdir+hdl
+incdir+bench
hdl/core_ctrl_pkg.sv
hdl/ctrl_fsm.sv
hdl/ctrl_redirect_encoder.sv
hdl/core_ctrl.sv
bench/tb_core_ctrl.sv

// File: hdl/core_ctrl.sv
`timescale 1ns/1ns

`include "core_ctrl_cfg.svh"

module core_ctrl (
  input  logic                          clk,
  input  logic                          rst_n,

  input  logic                          fetch_enable_i,
  input  logic                          illegal_insn_i,
  input  logic                          ecall_insn_i,
  input  logic                          mret_insn_i,
  input  logic                          pipe_flush_i,
  input  logic                          ebrk_insn_i,
  input  logic                          csr_status_i,
  input  logic                          instr_valid_i,
  input  logic                          branch_in_id_i,
  input  logic                          branch_set_i,
  input  logic                          jump_set_i,
  input  logic                          instr_multicycle_i,
  input  logic                          irq_req_i,
  input  logic [`CTRL_IRQ_ID_W-1:0]     irq_id_i,
  input  logic                          m_ie_i,
  input  logic                          id_ready_i,

  // status and stall controls
  output logic                          ctrl_busy_o,
  output logic                          first_fetch_o,
  output logic                          is_decoding_o,
  output logic                          deassert_we_o,
  output logic                          instr_req_o,
  output logic                          halt_if_o,
  output logic                          halt_id_o,
  output logic                          exc_kill_o,
  output logic [`CTRL_IRQ_ID_W-1:0]     irq_id_o,

  // redirect, causes and csr strobes
  output logic                          pc_set_o,
  output logic [`CTRL_PC_MUX_W-1:0]     pc_mux_o,
  output logic [`CTRL_EXC_PC_W-1:0]     exc_pc_mux_o,
  output logic [`CTRL_CAUSE_W-1:0]      exc_cause_o,
  output logic [`CTRL_CAUSE_W-1:0]      csr_cause_o,
  output logic                          csr_save_if_o,
  output logic                          csr_save_id_o,
  output logic                          csr_save_cause_o,
  output logic                          csr_restore_mret_o,
  output logic                          irq_ack_o,
  output logic                          exc_ack_o,
  output logic                          perf_jump_o,
  output logic                          perf_tbranch_o
);

  import core_ctrl_pkg::*;

  // decision from the fsm
  ctrl_act_e                 act;
  // irq id as seen by the fsm
  logic [`CTRL_IRQ_ID_W-1:0] irq_id;

  assign irq_id_o = irq_id;

  //////////////////////////////////////////////////////////////////////
  // state machine and redirect encoder
  //////////////////////////////////////////////////////////////////////

  ctrl_fsm ctrl_fsm_i (
    .clk                (clk),
    .rst_n              (rst_n),
    .fetch_enable_i     (fetch_enable_i),
    .illegal_insn_i     (illegal_insn_i),
    .ecall_insn_i       (ecall_insn_i),
    .mret_insn_i        (mret_insn_i),
    .pipe_flush_i       (pipe_flush_i),
    .ebrk_insn_i        (ebrk_insn_i),
    .csr_status_i       (csr_status_i),
    .instr_valid_i      (instr_valid_i),
    .branch_in_id_i     (branch_in_id_i),
    .branch_set_i       (branch_set_i),
    .jump_set_i         (jump_set_i),
    .instr_multicycle_i (instr_multicycle_i),
    .irq_req_i          (irq_req_i),
    .irq_id_i           (irq_id_i),
    .m_ie_i             (m_ie_i),
    .id_ready_i         (id_ready_i),
    .ctrl_busy_o        (ctrl_busy_o),
    .first_fetch_o      (first_fetch_o),
    .is_decoding_o      (is_decoding_o),
    .deassert_we_o      (deassert_we_o),
    .instr_req_o        (instr_req_o),
    .halt_if_o          (halt_if_o),
    .halt_id_o          (halt_id_o),
    .exc_kill_o         (exc_kill_o),
    .act_o              (act),
    .irq_id_o           (irq_id)
  );

  ctrl_redirect_encoder ctrl_redirect_encoder_i (
    .act_i              (act),
    .irq_id_i           (irq_id),
    .pc_set_o           (pc_set_o),
    .pc_mux_o           (pc_mux_o),
    .exc_pc_mux_o       (exc_pc_mux_o),
    .exc_cause_o        (exc_cause_o),
    .csr_cause_o        (csr_cause_o),
    .csr_save_if_o      (csr_save_if_o),
    .csr_save_id_o      (csr_save_id_o),
    .csr_save_cause_o   (csr_save_cause_o),
    .csr_restore_mret_o (csr_restore_mret_o),
    .irq_ack_o          (irq_ack_o),
    .exc_ack_o          (exc_ack_o),
    .perf_jump_o        (perf_jump_o),
    .perf_tbranch_o     (perf_tbranch_o)
  );

  // acknowledge is a single cycle strobe, fsm leaves IRQ_TAKEN at once
  a_irq_ack_pulse: assert property (
    @(posedge clk) disable iff (!rst_n)
    irq_ack_o |=> !irq_ack_o
  ) else $error("irq acknowledge held for more than one cycle");

endmodule

// File: hdl/core_ctrl_cfg.svh
`ifndef CORE_CTRL_CFG_SVH
`define CORE_CTRL_CFG_SVH

// interrupt id coming from the interrupt controller
`define CTRL_IRQ_ID_W 5

// mcause width, msb marks an interrupt
`define CTRL_CAUSE_W 6

// fetch stage pc select
`define CTRL_PC_MUX_W 3

// exception vector select
`define CTRL_EXC_PC_W 2

// synchronous exception causes, privileged spec numbering
`define CTRL_CAUSE_ILLEGAL    6'd2
`define CTRL_CAUSE_BREAKPOINT 6'd3
`define CTRL_CAUSE_ECALL_M    6'd11

`endif

// File: hdl/core_ctrl_pkg.sv
`include "core_ctrl_cfg.svh"

package core_ctrl_pkg;

  // controller states, debug states are gone
  typedef enum logic [3:0] {
    RESET,
    BOOT_SET,
    WAIT_SLEEP,
    SLEEP,
    FIRST_FETCH,
    DECODE,
    FLUSH,
    IRQ_TAKEN
  } ctrl_state_e;

  // what the controller does this cycle, fsm to encoder
  typedef enum logic [3:0] {
    ACT_NONE,
    ACT_BOOT,
    ACT_BRANCH,
    ACT_JUMP,
    ACT_IRQ,
    ACT_ECALL,
    ACT_ILLEGAL,
    ACT_MRET,
    ACT_EBREAK
  } ctrl_act_e;

  // fetch stage pc select, values match the if stage mux
  typedef enum logic [`CTRL_PC_MUX_W-1:0] {
    PC_BOOT      = 3'd0,
    PC_JUMP      = 3'd2,
    PC_EXCEPTION = 3'd4,
    PC_ERET      = 3'd5
  } pc_mux_e;

  // exception vector offset select
  typedef enum logic [`CTRL_EXC_PC_W-1:0] {
    EXC_PC_ILLINSN = 2'd0,
    EXC_PC_ECALL   = 2'd1,
    EXC_PC_IRQ     = 2'd3
  } exc_pc_mux_e;

endpackage

// File: hdl/ctrl_fsm.sv
`timescale 1ns/1ns

`include "core_ctrl_cfg.svh"

module ctrl_fsm (
  input  logic                          clk,
  input  logic                          rst_n,

  // start of execution
  input  logic                          fetch_enable_i,

  // decoder flags, at most one high per cycle
  input  logic                          illegal_insn_i,
  input  logic                          ecall_insn_i,
  input  logic                          mret_insn_i,
  input  logic                          pipe_flush_i,
  input  logic                          ebrk_insn_i,
  input  logic                          csr_status_i,

  // if/id pipeline and branch unit
  input  logic                          instr_valid_i,
  input  logic                          branch_in_id_i,
  input  logic                          branch_set_i,
  input  logic                          jump_set_i,
  input  logic                          instr_multicycle_i,

  // interrupt controller and csr
  input  logic                          irq_req_i,
  input  logic [`CTRL_IRQ_ID_W-1:0]     irq_id_i,
  input  logic                          m_ie_i,

  // id stage ready for a new instruction
  input  logic                          id_ready_i,

  output logic                          ctrl_busy_o,
  output logic                          first_fetch_o,
  output logic                          is_decoding_o,
  output logic                          deassert_we_o,
  output logic                          instr_req_o,
  output logic                          halt_if_o,
  output logic                          halt_id_o,
  output logic                          exc_kill_o,

  // decision for the redirect encoder
  output core_ctrl_pkg::ctrl_act_e      act_o,
  output logic [`CTRL_IRQ_ID_W-1:0]     irq_id_o
);

  import core_ctrl_pkg::*;

  ctrl_state_e state_q;
  ctrl_state_e state_d;

  // interrupt pending and enabled in mstatus
  logic irq_enabled;
  // instruction in id can be interrupted safely
  logic irq_window;
  // any instruction that needs a pipeline flush
  logic flush_insn;

  assign irq_enabled = irq_req_i & m_ie_i;
  assign irq_window  = ~instr_multicycle_i & ~branch_in_id_i;
  assign flush_insn  = illegal_insn_i | ecall_insn_i | mret_insn_i |
                       pipe_flush_i | ebrk_insn_i | csr_status_i;

  // id travels untouched to the encoder
  assign irq_id_o = irq_id_i;

  //////////////////////////////////////////////////////////////////////
  // next state and control decisions
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    // defaults, fetch running and no redirect
    state_d       = state_q;
    act_o         = ACT_NONE;
    instr_req_o   = 1'b1;
    ctrl_busy_o   = 1'b1;
    is_decoding_o = 1'b0;
    first_fetch_o = 1'b0;
    halt_if_o     = 1'b0;
    halt_id_o     = 1'b0;
    exc_kill_o    = 1'b0;

    unique case (state_q)
      // idle until fetch enable
      RESET: begin
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        if (fetch_enable_i) begin
          state_d = BOOT_SET;
        end
      end

      // load boot address into the prefetcher
      BOOT_SET: begin
        act_o   = ACT_BOOT;
        state_d = FIRST_FETCH;
      end

      // one cycle to let the pipe drain before sleeping
      WAIT_SLEEP: begin
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        halt_if_o   = 1'b1;
        halt_id_o   = 1'b1;
        state_d     = SLEEP;
      end

      // clock can be gated here
      // wake on fetch enable or any interrupt request, masked or not
      SLEEP: begin
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        halt_if_o   = 1'b1;
        halt_id_o   = 1'b1;
        if (fetch_enable_i || irq_req_i) begin
          state_d = FIRST_FETCH;
        end
      end

      // wait for the first instruction to reach id
      FIRST_FETCH: begin
        first_fetch_o = 1'b1;
        if (id_ready_i) begin
          state_d = DECODE;
        end
        // pipe is empty here, an interrupt can be taken right away
        if (irq_enabled) begin
          state_d   = IRQ_TAKEN;
          halt_if_o = 1'b1;
          halt_id_o = 1'b1;
        end
      end

      DECODE: begin
        if (instr_valid_i) begin
          is_decoding_o = 1'b1;
          // taken branch and jump redirect in the same cycle
          if (branch_set_i) begin
            act_o = ACT_BRANCH;
          end else if (jump_set_i) begin
            act_o = ACT_JUMP;
          end else if (flush_insn) begin
            // hold id so the flag is still there in FLUSH
            state_d   = FLUSH;
            halt_if_o = 1'b1;
            halt_id_o = 1'b1;
          end else if (irq_enabled && irq_window) begin
            state_d   = IRQ_TAKEN;
            halt_if_o = 1'b1;
            halt_id_o = 1'b1;
          end else begin
            // masked interrupt in a safe window, hint to kill exceptions
            exc_kill_o = irq_req_i & ~m_ie_i & irq_window;
          end
        end else if (irq_enabled) begin
          // bubble in id, nothing to protect
          state_d   = IRQ_TAKEN;
          halt_if_o = 1'b1;
          halt_id_o = 1'b1;
        end
      end

      // single cycle, encoder does the vector and cause
      IRQ_TAKEN: begin
        act_o   = ACT_IRQ;
        state_d = DECODE;
      end

      // flags are held stable by halt_id from the previous cycle
      FLUSH: begin
        halt_if_o = ~fetch_enable_i;
        halt_id_o = 1'b1;

        if (ecall_insn_i) begin
          act_o = ACT_ECALL;
        end else if (illegal_insn_i) begin
          act_o = ACT_ILLEGAL;
        end else if (mret_insn_i) begin
          act_o = ACT_MRET;
        end else if (ebrk_insn_i) begin
          act_o = ACT_EBREAK;
        end
        // csr_status and pipe_flush only flush, no redirect

        // mret and pipe flush act as wfi when fetch is disabled
        if (!fetch_enable_i && (mret_insn_i || pipe_flush_i)) begin
          state_d = WAIT_SLEEP;
        end else begin
          state_d = DECODE;
        end
      end

      default: begin
        instr_req_o = 1'b0;
        state_d     = RESET;
      end
    endcase
  end

  // no register writes when id holds nothing useful
  assign deassert_we_o = ~is_decoding_o | illegal_insn_i;

  //////////////////////////////////////////////////////////////////////
  // state register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= RESET;
    end else begin
      state_q <= state_d;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // assertions
  //////////////////////////////////////////////////////////////////////

  // decoder raises one flag at a time, priority above relies on it
  a_flags_onehot: assert property (
    @(posedge clk) disable iff (!rst_n)
    $onehot0({illegal_insn_i, ecall_insn_i, mret_insn_i, pipe_flush_i,
              ebrk_insn_i, csr_status_i, branch_set_i, jump_set_i})
  ) else $error("decoder flags not one-hot");

  // state register stays inside the legal encodings
  a_state_legal: assert property (
    @(posedge clk) disable iff (!rst_n)
    state_q inside {RESET, BOOT_SET, WAIT_SLEEP, SLEEP,
                    FIRST_FETCH, DECODE, FLUSH, IRQ_TAKEN}
  ) else $error("controller state out of range");

endmodule

// File: hdl/ctrl_redirect_encoder.sv
`timescale 1ns/1ns

`include "core_ctrl_cfg.svh"

module ctrl_redirect_encoder (
  // action chosen by the fsm this cycle
  input  core_ctrl_pkg::ctrl_act_e      act_i,
  input  logic [`CTRL_IRQ_ID_W-1:0]     irq_id_i,

  // prefetcher redirect
  output logic                          pc_set_o,
  output logic [`CTRL_PC_MUX_W-1:0]     pc_mux_o,
  output logic [`CTRL_EXC_PC_W-1:0]     exc_pc_mux_o,

  // cause codes, exception unit and mcause
  output logic [`CTRL_CAUSE_W-1:0]      exc_cause_o,
  output logic [`CTRL_CAUSE_W-1:0]      csr_cause_o,

  // csr strobes
  output logic                          csr_save_if_o,
  output logic                          csr_save_id_o,
  output logic                          csr_save_cause_o,
  output logic                          csr_restore_mret_o,

  // acknowledges
  output logic                          irq_ack_o,
  output logic                          exc_ack_o,

  // performance counter strobes
  output logic                          perf_jump_o,
  output logic                          perf_tbranch_o
);

  import core_ctrl_pkg::*;

  always_comb begin
    // defaults, no redirect and no strobes
    pc_set_o           = 1'b0;
    pc_mux_o           = PC_BOOT;
    exc_pc_mux_o       = EXC_PC_IRQ;
    exc_cause_o        = '0;
    csr_cause_o        = '0;
    csr_save_if_o      = 1'b0;
    csr_save_id_o      = 1'b0;
    csr_save_cause_o   = 1'b0;
    csr_restore_mret_o = 1'b0;
    irq_ack_o          = 1'b0;
    exc_ack_o          = 1'b0;
    perf_jump_o        = 1'b0;
    perf_tbranch_o     = 1'b0;

    unique case (act_i)
      ACT_BOOT: begin
        pc_set_o = 1'b1;
        pc_mux_o = PC_BOOT;
      end

      // target comes from the branch unit in id
      ACT_BRANCH: begin
        pc_set_o       = 1'b1;
        pc_mux_o       = PC_JUMP;
        perf_tbranch_o = 1'b1;
      end

      ACT_JUMP: begin
        pc_set_o    = 1'b1;
        pc_mux_o    = PC_JUMP;
        perf_jump_o = 1'b1;
      end

      // mepc from if stage, mcause msb set for interrupts
      ACT_IRQ: begin
        pc_set_o         = 1'b1;
        pc_mux_o         = PC_EXCEPTION;
        exc_pc_mux_o     = EXC_PC_IRQ;
        exc_cause_o      = {1'b0, irq_id_i};
        csr_cause_o      = {1'b1, irq_id_i};
        csr_save_if_o    = 1'b1;
        csr_save_cause_o = 1'b1;
        irq_ack_o        = 1'b1;
        exc_ack_o        = 1'b1;
      end

      // synchronous traps save the id stage pc
      ACT_ECALL: begin
        pc_set_o         = 1'b1;
        pc_mux_o         = PC_EXCEPTION;
        exc_pc_mux_o     = EXC_PC_ECALL;
        exc_cause_o      = `CTRL_CAUSE_ECALL_M;
        csr_cause_o      = `CTRL_CAUSE_ECALL_M;
        csr_save_id_o    = 1'b1;
        csr_save_cause_o = 1'b1;
      end

      ACT_ILLEGAL: begin
        pc_set_o         = 1'b1;
        pc_mux_o         = PC_EXCEPTION;
        exc_pc_mux_o     = EXC_PC_ILLINSN;
        exc_cause_o      = `CTRL_CAUSE_ILLEGAL;
        csr_cause_o      = `CTRL_CAUSE_ILLEGAL;
        csr_save_id_o    = 1'b1;
        csr_save_cause_o = 1'b1;
      end

      // back to mepc, csr file restores mstatus
      ACT_MRET: begin
        pc_set_o           = 1'b1;
        pc_mux_o           = PC_ERET;
        csr_restore_mret_o = 1'b1;
      end

      // without debug an ebreak only reports its cause
      ACT_EBREAK: begin
        exc_cause_o = `CTRL_CAUSE_BREAKPOINT;
      end

      default: begin
      end
    endcase
  end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# build the core_ctrl testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_core_ctrl -f core_ctrl.f \
  || { echo "build failed"; exit 1; }

./obj_dir/Vtb_core_ctrl | tee /dev/stderr | grep -qx "=== PASS ===" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
